// File: include/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define XLEN            64
`define ILEN            32
`define REG_IDX_W       5

`define RESET_PC        64'h0000_0000_0000_0000
`define REG_A0          5'd10
`define NOP_INSTR       32'h0000_0013       // addi x0, x0, 0

// major opcodes, instr[6:0]
`define OP_REG          7'b0110011
`define OP_IMM          7'b0010011
`define OP_LUI          7'b0110111
`define OP_AUIPC        7'b0010111
`define OP_BRANCH       7'b1100011
`define OP_JAL          7'b1101111
`define OP_JALR         7'b1100111

// funct3 of the alu group
`define F3_ADD          3'b000              // add/sub/addi
`define F3_SLL          3'b001
`define F3_SLT          3'b010
`define F3_SLTU         3'b011
`define F3_XOR          3'b100
`define F3_SR           3'b101              // srl/sra, instr[30] picks
`define F3_OR           3'b110
`define F3_AND          3'b111

// funct3 of the branch group
`define F3_BEQ          3'b000
`define F3_BNE          3'b001
`define F3_BLT          3'b100
`define F3_BGE          3'b101

`endif

// File: hdl/rv_pkg.sv
`default_nettype none
`include "rv_consts.svh"

package rv_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS                                // result is operand b, used by lui
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_JAL,
        BR_JALR
    } br_kind_e;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`ILEN-1:0]       instr;
        logic [`XLEN-1:0]       rs1_val;
        logic [`XLEN-1:0]       rs2_val;
        logic [`REG_IDX_W-1:0]  rs1_idx;
        logic [`REG_IDX_W-1:0]  rs2_idx;
        logic [`XLEN-1:0]       imm;
        alu_op_e                alu_op;
        logic                   src1_pc;        // operand a is pc
        logic                   src2_imm;       // operand b is imm
        br_kind_e               br_kind;
        logic [`REG_IDX_W-1:0]  rd;
        logic                   wb_en;
    } dec_pkt_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`ILEN-1:0]       instr;
        logic [`REG_IDX_W-1:0]  rd;
        logic                   wb_en;
        logic [`XLEN-1:0]       result;
    } exe_pkt_t;

endpackage

`default_nettype wire

// File: hdl/fetch_unit.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_consts.svh"

module fetch_unit (
    input  wire                     clk,
    input  wire                     arst_n_i,

    input  wire                     redirect_i,         // taken jump in execute
    input  wire  [`XLEN-1:0]        redirect_pc_i,

    output logic [`XLEN-1:0]        imem_addr_o,
    input  wire  [`ILEN-1:0]        imem_rdata_i,       // same-cycle read data

    output logic                    fd_valid_o,
    output logic [`XLEN-1:0]        fd_pc_o,
    output logic [`ILEN-1:0]        fd_instr_o
);

    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] pc_next;

    assign imem_addr_o = pc_q;

    // redirect wins over sequential fetch
    assign pc_next = redirect_i ? redirect_pc_i : pc_q + 4;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q       <= `RESET_PC;
            fd_valid_o <= 1'b0;
        end else begin
            pc_q       <= pc_next;
            fd_valid_o <= !redirect_i;                  // squash the wrong-path word
        end
    end

    always_ff @(posedge clk) begin
        fd_pc_o    <= pc_q;
        fd_instr_o <= imem_rdata_i;
    end

endmodule

`default_nettype wire

// File: hdl/decode_unit.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_consts.svh"

module decode_unit
    import rv_pkg::*;
(
    input  wire                     clk,
    input  wire                     arst_n_i,

    input  wire                     fd_valid_i,
    input  wire  [`XLEN-1:0]        fd_pc_i,
    input  wire  [`ILEN-1:0]        fd_instr_i,
    input  wire                     flush_i,

    input  wire                     wb_en_i,            // from retire
    input  wire  [`REG_IDX_W-1:0]   wb_rd_i,
    input  wire  [`XLEN-1:0]        wb_data_i,

    output dec_pkt_t                dec_pkt_o,
    output logic [`XLEN-1:0]        reg_a0_o
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [`REG_IDX_W-1:0]  rs1_idx;
    logic [`REG_IDX_W-1:0]  rs2_idx;
    logic [`XLEN-1:0]       imm_i;
    logic [`XLEN-1:0]       imm_u;
    logic [`XLEN-1:0]       imm_b;
    logic [`XLEN-1:0]       imm_j;
    logic [`XLEN-1:0]       regs [1:31];                // x0 is not stored
    dec_pkt_t               pkt_d;
    dec_pkt_t               pkt_q;
    logic                   valid_q;

    assign opcode  = fd_instr_i[6:0];
    assign funct3  = fd_instr_i[14:12];
    assign rs1_idx = fd_instr_i[19:15];
    assign rs2_idx = fd_instr_i[24:20];

    assign imm_i = {{(`XLEN-12){fd_instr_i[31]}}, fd_instr_i[31:20]};
    assign imm_u = {{(`XLEN-32){fd_instr_i[31]}}, fd_instr_i[31:12], 12'b0};
    assign imm_b = {{(`XLEN-13){fd_instr_i[31]}}, fd_instr_i[31], fd_instr_i[7],
                    fd_instr_i[30:25], fd_instr_i[11:8], 1'b0};
    assign imm_j = {{(`XLEN-21){fd_instr_i[31]}}, fd_instr_i[31], fd_instr_i[19:12],
                    fd_instr_i[20], fd_instr_i[30:21], 1'b0};

    // x0 reads zero, a same-cycle write is passed through
    function automatic logic [`XLEN-1:0] read_reg(input logic [`REG_IDX_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_en_i && wb_rd_i == idx) begin
            return wb_data_i;
        end
        return regs[idx];
    endfunction

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            `F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            `F3_SLL:  return ALU_SLL;
            `F3_SLT:  return ALU_SLT;
            `F3_SLTU: return ALU_SLTU;
            `F3_XOR:  return ALU_XOR;
            `F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            `F3_OR:   return ALU_OR;
            default:  return ALU_AND;
        endcase
    endfunction

    always_comb begin
        pkt_d         = '0;
        pkt_d.valid   = fd_valid_i && !flush_i;
        pkt_d.pc      = fd_pc_i;
        pkt_d.instr   = fd_instr_i;
        pkt_d.rs1_idx = rs1_idx;
        pkt_d.rs2_idx = rs2_idx;
        pkt_d.rs1_val = read_reg(rs1_idx);
        pkt_d.rs2_val = read_reg(rs2_idx);
        pkt_d.rd      = fd_instr_i[11:7];
        pkt_d.alu_op  = ALU_ADD;
        pkt_d.br_kind = BR_NONE;
        case (opcode)
            `OP_REG: begin
                pkt_d.wb_en  = 1'b1;
                pkt_d.alu_op = alu_sel(funct3, fd_instr_i[30]);
            end
            `OP_IMM: begin
                pkt_d.wb_en    = 1'b1;
                pkt_d.src2_imm = 1'b1;
                pkt_d.imm      = imm_i;                 // shamt sits in imm[5:0]
                pkt_d.alu_op   = alu_sel(funct3, funct3 == `F3_SR && fd_instr_i[30]);
            end
            `OP_LUI: begin
                pkt_d.wb_en    = 1'b1;
                pkt_d.src2_imm = 1'b1;
                pkt_d.imm      = imm_u;
                pkt_d.alu_op   = ALU_PASS;
            end
            `OP_AUIPC: begin
                pkt_d.wb_en    = 1'b1;
                pkt_d.src1_pc  = 1'b1;
                pkt_d.src2_imm = 1'b1;
                pkt_d.imm      = imm_u;
            end
            `OP_BRANCH: begin
                pkt_d.imm = imm_b;
                case (funct3)
                    `F3_BEQ: pkt_d.br_kind = BR_EQ;
                    `F3_BNE: pkt_d.br_kind = BR_NE;
                    `F3_BLT: pkt_d.br_kind = BR_LT;
                    `F3_BGE: pkt_d.br_kind = BR_GE;
                    default: pkt_d.br_kind = BR_NONE;   // bltu/bgeu fall through as nop
                endcase
            end
            `OP_JAL: begin
                pkt_d.wb_en   = 1'b1;
                pkt_d.imm     = imm_j;
                pkt_d.br_kind = BR_JAL;
            end
            `OP_JALR: begin
                pkt_d.wb_en   = 1'b1;
                pkt_d.imm     = imm_i;
                pkt_d.br_kind = BR_JALR;
            end
            default: ;                                  // unknown opcode, no write
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb_en_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    assign reg_a0_o = regs[`REG_A0];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pkt_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        pkt_q <= pkt_d;
    end

    always_comb begin
        dec_pkt_o       = pkt_q;
        dec_pkt_o.valid = valid_q;
    end

endmodule

`default_nettype wire

// File: hdl/execute_unit.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_consts.svh"

module execute_unit
    import rv_pkg::*;
(
    input  wire                     clk,
    input  wire                     arst_n_i,

    input  wire  dec_pkt_t          dec_pkt_i,

    input  wire                     wb_en_i,            // forwarding source
    input  wire  [`REG_IDX_W-1:0]   wb_rd_i,
    input  wire  [`XLEN-1:0]        wb_data_i,

    output logic                    redirect_o,         // also flushes fetch and decode
    output logic [`XLEN-1:0]        redirect_pc_o,

    output exe_pkt_t                exe_pkt_o
);

    logic [`XLEN-1:0]   rs1_val;
    logic [`XLEN-1:0]   rs2_val;
    logic [`XLEN-1:0]   src_a;
    logic [`XLEN-1:0]   src_b;
    logic [5:0]         shamt;
    logic [`XLEN-1:0]   alu_res;
    logic [`XLEN-1:0]   link_pc;
    logic [`XLEN-1:0]   jalr_sum;
    logic               taken;
    logic               is_jump;
    exe_pkt_t           pkt_d;
    exe_pkt_t           pkt_q;
    logic               valid_q;

    // wb_en_i is already qualified by valid and rd != 0
    function automatic logic [`XLEN-1:0] fwd_operand(input logic [`REG_IDX_W-1:0] idx,
                                                     input logic [`XLEN-1:0] dec_val);
        if (wb_en_i && wb_rd_i == idx) begin
            return wb_data_i;
        end
        return dec_val;
    endfunction

    always_comb begin
        rs1_val = fwd_operand(dec_pkt_i.rs1_idx, dec_pkt_i.rs1_val);
        rs2_val = fwd_operand(dec_pkt_i.rs2_idx, dec_pkt_i.rs2_val);
    end

    assign src_a = dec_pkt_i.src1_pc  ? dec_pkt_i.pc  : rs1_val;
    assign src_b = dec_pkt_i.src2_imm ? dec_pkt_i.imm : rs2_val;
    assign shamt = src_b[5:0];                          // rv64 shifts use 6 bits

    always_comb begin
        case (dec_pkt_i.alu_op)
            ALU_ADD:  alu_res = src_a + src_b;
            ALU_SUB:  alu_res = src_a - src_b;
            ALU_AND:  alu_res = src_a & src_b;
            ALU_OR:   alu_res = src_a | src_b;
            ALU_XOR:  alu_res = src_a ^ src_b;
            ALU_SLT:  alu_res = {{(`XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ALU_SLTU: alu_res = {{(`XLEN-1){1'b0}}, src_a < src_b};
            ALU_SLL:  alu_res = src_a << shamt;
            ALU_SRL:  alu_res = src_a >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(src_a) >>> shamt);
            default:  alu_res = src_b;                  // pass for lui
        endcase
    end

    assign link_pc  = dec_pkt_i.pc + 4;
    assign jalr_sum = rs1_val + dec_pkt_i.imm;
    assign is_jump  = (dec_pkt_i.br_kind == BR_JAL) || (dec_pkt_i.br_kind == BR_JALR);

    always_comb begin
        case (dec_pkt_i.br_kind)
            BR_EQ:   taken = (rs1_val == rs2_val);
            BR_NE:   taken = (rs1_val != rs2_val);
            BR_LT:   taken = ($signed(rs1_val) <  $signed(rs2_val));
            BR_GE:   taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o    = dec_pkt_i.valid && taken;
    assign redirect_pc_o = (dec_pkt_i.br_kind == BR_JALR) ? {jalr_sum[`XLEN-1:1], 1'b0}
                                                          : dec_pkt_i.pc + dec_pkt_i.imm;

    always_comb begin
        pkt_d        = '0;
        pkt_d.valid  = dec_pkt_i.valid;
        pkt_d.pc     = dec_pkt_i.pc;
        pkt_d.instr  = dec_pkt_i.instr;
        pkt_d.rd     = dec_pkt_i.rd;
        pkt_d.wb_en  = dec_pkt_i.wb_en;
        pkt_d.result = is_jump ? link_pc : alu_res;     // link value for jal/jalr
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pkt_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        pkt_q <= pkt_d;
    end

    always_comb begin
        exe_pkt_o       = pkt_q;
        exe_pkt_o.valid = valid_q;
    end

endmodule

`default_nettype wire

// File: hdl/retire_unit.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_consts.svh"

module retire_unit
    import rv_pkg::*;
(
    input  wire                     clk,
    input  wire                     arst_n_i,

    input  wire  exe_pkt_t          exe_pkt_i,

    output logic                    wb_en_o,            // to regfile and forwarding
    output logic [`REG_IDX_W-1:0]   wb_rd_o,
    output logic [`XLEN-1:0]        wb_data_o,

    output logic                    retire_valid_o,     // one pulse per instruction
    output logic [`XLEN-1:0]        retire_pc_o,
    output logic [`ILEN-1:0]        retire_instr_o
);

    // x0 and bubbles never reach the register file
    assign wb_en_o   = exe_pkt_i.valid && exe_pkt_i.wb_en && (exe_pkt_i.rd != '0);
    assign wb_rd_o   = exe_pkt_i.rd;
    assign wb_data_o = exe_pkt_i.result;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= exe_pkt_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc_o    <= exe_pkt_i.pc;
        retire_instr_o <= exe_pkt_i.instr;
    end

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core
    import rv_pkg::*;
(
    input  wire                     clk,
    input  wire                     arst_n_i,

    output logic [`XLEN-1:0]        imem_addr_o,
    input  wire  [`ILEN-1:0]        imem_rdata_i,

    output logic                    retire_valid_o,     // debug retire port
    output logic [`XLEN-1:0]        retire_pc_o,
    output logic [`ILEN-1:0]        retire_instr_o,
    output logic [`XLEN-1:0]        reg_a0_o
);

    logic                   fd_valid;
    logic [`XLEN-1:0]       fd_pc;
    logic [`ILEN-1:0]       fd_instr;
    logic                   redirect;
    logic [`XLEN-1:0]       redirect_pc;
    dec_pkt_t               dec_pkt;
    exe_pkt_t               exe_pkt;
    logic                   wb_en;
    logic [`REG_IDX_W-1:0]  wb_rd;
    logic [`XLEN-1:0]       wb_data;

    fetch_unit fetch_u (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .redirect_i     (redirect),
        .redirect_pc_i  (redirect_pc),
        .imem_addr_o    (imem_addr_o),
        .imem_rdata_i   (imem_rdata_i),
        .fd_valid_o     (fd_valid),
        .fd_pc_o        (fd_pc),
        .fd_instr_o     (fd_instr)
    );

    decode_unit decode_u (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .fd_valid_i     (fd_valid),
        .fd_pc_i        (fd_pc),
        .fd_instr_i     (fd_instr),
        .flush_i        (redirect),                     // same pulse squashes decode
        .wb_en_i        (wb_en),
        .wb_rd_i        (wb_rd),
        .wb_data_i      (wb_data),
        .dec_pkt_o      (dec_pkt),
        .reg_a0_o       (reg_a0_o)
    );

    execute_unit execute_u (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .dec_pkt_i      (dec_pkt),
        .wb_en_i        (wb_en),
        .wb_rd_i        (wb_rd),
        .wb_data_i      (wb_data),
        .redirect_o     (redirect),
        .redirect_pc_o  (redirect_pc),
        .exe_pkt_o      (exe_pkt)
    );

    retire_unit retire_u (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .exe_pkt_i      (exe_pkt),
        .wb_en_o        (wb_en),
        .wb_rd_o        (wb_rd),
        .wb_data_o      (wb_data),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_instr_o (retire_instr_o)
    );

endmodule

`default_nettype wire

// File: tb/rv_core_assert.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_assert (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire                     retire_valid_i,
    input  wire  [`XLEN-1:0]        retire_pc_i
);

    logic retired_q;                                    // something retired since reset
    int   fail_count = 0;                               // assertion failures so far

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retired_q <= 1'b0;
        end else if (retire_valid_i) begin
            retired_q <= 1'b1;
        end
    end

    quiet_in_reset: assert property (@(posedge clk) !arst_n_i |-> !retire_valid_i)
        else begin
            $error("retire pulse while reset is asserted");
            fail_count++;
        end

    // first clocked cycle after release
    quiet_after_release: assert property (@(posedge clk) $rose(arst_n_i) |=> !retire_valid_i)
        else begin
            $error("retire pulse in the cycle after reset release");
            fail_count++;
        end

    pc_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        retire_valid_i |-> retire_pc_i[1:0] == 2'b00)
        else begin
            $error("retired pc is not word aligned");
            fail_count++;
        end

    first_pc: assert property (@(posedge clk) disable iff (!arst_n_i)
        retire_valid_i && !retired_q |-> retire_pc_i == `RESET_PC)
        else begin
            $error("first retired pc differs from the reset pc");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: tb/rv_core_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb;

    localparam int STIM_DEPTH = 256;
    localparam int PROG_BASE  = 2;                      // after the two header words
    localparam int REC_W      = 5;                      // words per retire record

    logic               clk;
    logic               arst_n;
    logic [`XLEN-1:0]   imem_addr;
    logic [`ILEN-1:0]   imem_rdata;
    logic               retire_valid;
    logic [`XLEN-1:0]   retire_pc;
    logic [`ILEN-1:0]   retire_instr;
    logic [`XLEN-1:0]   reg_a0;
    logic [63:0]        stim_mem [0:STIM_DEPTH-1];
    int                 prog_len;
    int                 rec_count;
    int                 rec_idx;
    int                 err_count;
    int                 test_recs;
    int                 test_errs;
    int                 tests_done;
    int                 quiet_left;                     // quiet cycles still checked after release

    rv_core u_dut (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .imem_addr_o    (imem_addr),
        .imem_rdata_i   (imem_rdata),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_instr_o (retire_instr),
        .reg_a0_o       (reg_a0)
    );

    bind rv_core rv_core_assert u_assert (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .retire_valid_i (retire_valid_o),
        .retire_pc_i    (retire_pc_o)
    );

    always #5 clk = ~clk;

    // words past the program read as nop
    function automatic logic [`ILEN-1:0] fetch_word(input logic [`XLEN-1:0] addr);
        logic [`XLEN-1:0] idx;
        idx = addr >> 2;
        if (addr[1:0] == 2'b00 && idx < prog_len) begin
            return stim_mem[PROG_BASE + idx][`ILEN-1:0];
        end
        return `NOP_INSTR;
    endfunction

    function automatic string test_name(input logic [63:0] id);
        case (id)
            1:       return "reset";
            2:       return "alu and immediates";
            3:       return "forwarding";
            4:       return "branches";
            5:       return "jumps";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_record();
        int          base;
        logic [63:0] tid;
        logic [63:0] exp_pc;
        logic [63:0] exp_instr;
        logic [63:0] exp_a0;
        logic        last;
        base      = PROG_BASE + prog_len + rec_idx * REC_W;
        tid       = stim_mem[base];
        exp_pc    = stim_mem[base + 2];
        exp_instr = stim_mem[base + 3];
        exp_a0    = stim_mem[base + 4];
        test_recs++;
        if (retire_pc !== exp_pc) begin
            $display("FAILED at %0t: record %0d retired pc %h, expected %h",
                     $time, rec_idx, retire_pc, exp_pc);
            test_errs++;
        end
        if (retire_instr !== exp_instr[`ILEN-1:0]) begin
            $display("FAILED at %0t: record %0d retired instr %h, expected %h",
                     $time, rec_idx, retire_instr, exp_instr[`ILEN-1:0]);
            test_errs++;
        end
        if (stim_mem[base + 1][0] && reg_a0 !== exp_a0) begin  // a0 check flag
            $display("FAILED at %0t: record %0d a0 %h, expected %h",
                     $time, rec_idx, reg_a0, exp_a0);
            test_errs++;
        end
        last = (rec_idx + 1 == rec_count) || (stim_mem[base + REC_W] != tid);
        if (last) begin
            $display("test %0d (%s) done: %0d records, %0d errors",
                     tid, test_name(tid), test_recs, test_errs);
            err_count += test_errs;
            tests_done++;
            test_recs = 0;
            test_errs = 0;
        end
        rec_idx++;
    endtask

    always @(posedge clk) begin
        #1;
        imem_rdata = fetch_word(imem_addr);             // word at the new pc
    end

    // outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (!arst_n || quiet_left > 0) begin
            if (retire_valid !== 1'b0) begin
                $display("FAILED at %0t: retire pulse during reset or right after release",
                         $time);
                err_count++;
            end
            quiet_left = arst_n ? quiet_left - 1 : 2;
        end else if (retire_valid === 1'b1 && rec_idx < rec_count) begin
            check_record();
        end
    end

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b1;
        imem_rdata = `NOP_INSTR;
        prog_len   = 0;
        rec_count  = 0;
        rec_idx    = 0;
        err_count  = 0;
        test_recs  = 0;
        test_errs  = 0;
        tests_done = 0;
        quiet_left = 2;
        $readmemh("tb/rv_core_stim.txt", stim_mem);
        if ($isunknown(stim_mem[0]) || $isunknown(stim_mem[1]) || stim_mem[1] == 0 ||
            PROG_BASE + stim_mem[0] + REC_W * stim_mem[1] > STIM_DEPTH) begin
            $display("stim file is missing or its header is malformed");
            err_count++;
        end else begin
            prog_len  = int'(stim_mem[0]);
            rec_count = int'(stim_mem[1]);
        end
        #1;
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        wait (rec_idx == rec_count);
        err_count += u_dut.u_assert.fail_count;
        $display("%0d tests done, %0d of %0d records checked, %0d errors",
                 tests_done, rec_idx, rec_count, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // four cycles per record covers the jump bubbles with margin
    initial begin
        @(posedge arst_n);
        repeat (rec_count * 4 + 100) @(posedge clk);
        $display("timeout: only %0d of %0d records retired in time", rec_idx, rec_count);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
hdl/rv_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/retire_unit.sv
hdl/rv_core.sv
tb/rv_core_assert.sv
tb/rv_core_tb.sv

// File: tb/rv_core_stim.txt
// header: program word count, record count; then program words from pc 0, four per line
// records: test id, a0 check flag, retired pc, retired instruction, expected a0
27 1E
123452B7 67828513 00001517 FFF00313 // 000: lui x5, addi a0, auipc a0, addi x6 -1
55534513 40455513 03C35513 00032533 // 010: xori, srai, srli a0 x6 60, slt
00033533 00300393 7FF00E13 00729533 // 020: sltu, addi x7 3, addi x28 7ff, sll
01C54533 00755533 40A00EB3 407ED533 // 030: xor, srl, sub x29, sra
00738463 00100513 00030463 00739463 // 040: beq taken, squashed, beq not, bne not
00031463 00200513 00604463 00034463 // 050: bne taken, squashed, blt not, blt taken
00300513 00035463 00605463 00400513 // 060: squashed, bge not, bge taken, squashed
00550513 00C000EF 00600513 00700513 // 070: addi a0 a0 5, jal x1 +12, squashed x2
00008513 09500293 004280E7 00800513 // 080: addi a0 x1, addi x5 95, jalr x1 x5 4
00900513 00A00513 00008513          // 090: squashed, skipped, addi a0 x1
1 0 000 123452B7 0
2 1 004 67828513 12345678
2 1 008 00001517 1008
2 1 00C FFF00313 1008
2 1 010 55534513 FFFFFFFFFFFFFAAA
2 1 014 40455513 FFFFFFFFFFFFFFAA
2 1 018 03C35513 F
2 1 01C 00032533 1
2 1 020 00033533 0
3 1 024 00300393 0
3 1 028 7FF00E13 0
3 1 02C 00729533 91A28000
3 1 030 01C54533 91A287FF
3 1 034 00755533 123450FF
3 1 038 40A00EB3 123450FF
3 1 03C 407ED533 FFFFFFFFFDB975E0
4 1 040 00738463 FFFFFFFFFDB975E0
4 1 048 00030463 FFFFFFFFFDB975E0
4 1 04C 00739463 FFFFFFFFFDB975E0
4 1 050 00031463 FFFFFFFFFDB975E0
4 1 058 00604463 FFFFFFFFFDB975E0
4 1 05C 00034463 FFFFFFFFFDB975E0
4 1 064 00035463 FFFFFFFFFDB975E0
4 1 068 00605463 FFFFFFFFFDB975E0
4 1 070 00550513 FFFFFFFFFDB975E5
5 1 074 00C000EF FFFFFFFFFDB975E5
5 1 080 00008513 78
5 1 084 09500293 78
5 1 088 004280E7 78
5 1 098 00008513 8C
